// File: rtl/mem_pkg.sv
// Main-memory bus types and timing; word addresses are byte addresses with bit 0 ignored
`default_nettype none

package mem_pkg;

    typedef logic [15:0] addr_t;                // Byte address on the memory bus
    typedef logic [15:0] word_t;                // One 16-bit data word

    localparam int MEM_LATENCY = 4;             // Cycles from a read strobe to its valid data
    localparam int MEM_WORDS   = 32768;         // Full 64 KB byte space held as 16-bit words

endpackage

`default_nettype wire

// File: rtl/cache_pkg.sv
// Cache block geometry and fill FSM states; blocks are 16 bytes of 16-bit words, never partial
`default_nettype none

package cache_pkg;

    localparam int WORDS_PER_BLOCK = 8;         // Eight words make one 16-byte block
    localparam int OFFSET_W        = 4;         // Byte offset bits inside a block

    typedef logic [3:0] word_cnt_t;             // Wide enough to reach WORDS_PER_BLOCK itself

    typedef enum logic [1:0] {
        FILL_IDLE,                              // Waiting for a granted miss
        FILL_RUN,                               // Issuing reads and collecting returns
        FILL_DONE                               // One closing busy cycle before going idle
    } fill_state_t;

endpackage

`default_nettype wire

// File: rtl/cache_fill_fsm.sv
// One-block fill FSM; expects miss_address stable from the cycle after the miss is taken
`timescale 1ns/10ps
`default_nettype none

module cache_fill_fsm (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           grant,              // This machine currently owns main memory
    input  logic           miss_detected,      // Level from the cache until it sees the tag write
    input  mem_pkg::addr_t miss_address,       // Latched miss address from the arbiter
    input  logic           data_valid,         // Read data valid, already steered to this machine
    output logic           fsm_busy,
    output logic           mem_rd,
    output mem_pkg::addr_t mem_addr,
    output mem_pkg::addr_t fill_addr,
    output logic           write_data_array,
    output logic           write_tag_array
);

    cache_pkg::fill_state_t state;
    cache_pkg::fill_state_t state_nxt;
    cache_pkg::word_cnt_t   issue_cnt;         // Reads sent so far in this block
    cache_pkg::word_cnt_t   ret_cnt;           // Words written back so far
    mem_pkg::addr_t         block_base;
    logic                   last_word;

    // Offset bits cleared so both counters step from the block start
    assign block_base = {miss_address[15:cache_pkg::OFFSET_W], {cache_pkg::OFFSET_W{1'b0}}};

    assign fsm_busy  = (state != cache_pkg::FILL_IDLE);
    assign mem_rd    = (state == cache_pkg::FILL_RUN) &&
                       (issue_cnt != cache_pkg::word_cnt_t'(cache_pkg::WORDS_PER_BLOCK));
    assign mem_addr  = block_base + mem_pkg::addr_t'({issue_cnt, 1'b0}); // Word step is 2 bytes
    assign fill_addr = block_base + mem_pkg::addr_t'({ret_cnt, 1'b0});   // Tracks the returning word

    assign write_data_array = (state == cache_pkg::FILL_RUN) && data_valid;
    assign last_word        = write_data_array &&
                              (ret_cnt == cache_pkg::word_cnt_t'(cache_pkg::WORDS_PER_BLOCK - 1));
    assign write_tag_array  = last_word;       // Tag goes in alongside the eighth word

    always_comb begin
        state_nxt = state;
        case (state)
            cache_pkg::FILL_IDLE: begin
                if (grant && miss_detected) begin  // Only the granted machine may start
                    state_nxt = cache_pkg::FILL_RUN;
                end
            end
            cache_pkg::FILL_RUN: begin
                if (last_word) begin
                    state_nxt = cache_pkg::FILL_DONE;
                end
            end
            cache_pkg::FILL_DONE: state_nxt = cache_pkg::FILL_IDLE; // Cache drops its miss here
            default:              state_nxt = cache_pkg::FILL_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= cache_pkg::FILL_IDLE;
            issue_cnt <= '0;
            ret_cnt   <= '0;
        end else begin
            state <= state_nxt;
            if (state == cache_pkg::FILL_IDLE) begin
                issue_cnt <= '0;                   // Ready for the next block
                ret_cnt   <= '0;
            end else begin
                if (mem_rd) begin
                    issue_cnt <= issue_cnt + 1'b1; // Issue runs ahead of the returns
                end
                if (write_data_array) begin
                    ret_cnt <= ret_cnt + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/cache_arbiter.sv
// Two-cache memory arbiter; the instruction cache wins a tie and write-through stores pass only outside a stall
`timescale 1ns/10ps
`default_nettype none

module cache_arbiter (
    input  logic           clk,
    input  logic           rst_n,
    output logic           stall_n,

    input  mem_pkg::addr_t icache_addr,
    input  logic           icache_miss_detected,
    output logic           icache_fsm_busy,
    output logic           icache_write_data_array,
    output logic           icache_write_tag_array,
    output mem_pkg::addr_t icache_fill_addr,
    output mem_pkg::word_t icache_fill_data,

    input  mem_pkg::addr_t dcache_addr,
    input  logic           dcache_miss_detected,
    output logic           dcache_fsm_busy,
    output logic           dcache_write_data_array,
    output logic           dcache_write_tag_array,
    output mem_pkg::addr_t dcache_fill_addr,
    output mem_pkg::word_t dcache_fill_data,
    input  mem_pkg::addr_t dcache_write_addr,
    input  mem_pkg::word_t dcache_write_data,
    input  logic           dcache_write_enable,

    output mem_pkg::addr_t mem_addr,
    output mem_pkg::word_t mem_write_data,
    output logic           mem_rd,
    output logic           mem_wr,
    input  mem_pkg::word_t mem_read_data,
    input  logic           mem_data_valid
);

    mem_pkg::addr_t icache_miss_addr;
    mem_pkg::addr_t dcache_miss_addr;
    mem_pkg::addr_t icache_mem_addr;
    mem_pkg::addr_t dcache_mem_addr;
    logic           icache_mem_rd;
    logic           dcache_mem_rd;
    logic           grant_dcache;          // High when the data cache owns memory
    logic           stall;

    // Miss addresses follow the cache only while its machine is idle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            icache_miss_addr <= '0;
            dcache_miss_addr <= '0;
        end else begin
            if (icache_miss_detected && !icache_fsm_busy) begin
                icache_miss_addr <= icache_addr;
            end
            if (dcache_miss_detected && !dcache_fsm_busy) begin
                dcache_miss_addr <= dcache_addr;
            end
        end
    end

    // Data cache wins alone or when it already runs and the other is idle
    assign grant_dcache = (!icache_miss_detected && dcache_miss_detected) ||
                          (icache_miss_detected && dcache_miss_detected &&
                           !icache_fsm_busy && dcache_fsm_busy);

    assign stall   = icache_fsm_busy || dcache_fsm_busy;
    assign stall_n = !stall;                // Processor waits during any fill

    cache_fill_fsm u_icache_fill (
        .clk              (clk),
        .rst_n            (rst_n),
        .grant            (!grant_dcache),
        .miss_detected    (icache_miss_detected),
        .miss_address     (icache_miss_addr),
        .data_valid       (mem_data_valid && !grant_dcache),
        .fsm_busy         (icache_fsm_busy),
        .mem_rd           (icache_mem_rd),
        .mem_addr         (icache_mem_addr),
        .fill_addr        (icache_fill_addr),
        .write_data_array (icache_write_data_array),
        .write_tag_array  (icache_write_tag_array)
    );

    cache_fill_fsm u_dcache_fill (
        .clk              (clk),
        .rst_n            (rst_n),
        .grant            (grant_dcache),
        .miss_detected    (dcache_miss_detected),
        .miss_address     (dcache_miss_addr),
        .data_valid       (mem_data_valid && grant_dcache),
        .fsm_busy         (dcache_fsm_busy),
        .mem_rd           (dcache_mem_rd),
        .mem_addr         (dcache_mem_addr),
        .fill_addr        (dcache_fill_addr),
        .write_data_array (dcache_write_data_array),
        .write_tag_array  (dcache_write_tag_array)
    );

    assign mem_addr = stall ? (grant_dcache ? dcache_mem_addr : icache_mem_addr)
                            : dcache_write_addr;      // Store address outside a stall
    assign mem_rd   = grant_dcache ? dcache_mem_rd : icache_mem_rd;
    assign mem_wr   = dcache_write_enable && !stall; // Stores never collide with fill reads
    assign mem_write_data = dcache_write_data;

    assign icache_fill_data = mem_read_data;   // Both see the data and the steered valid qualifies it
    assign dcache_fill_data = mem_read_data;

endmodule

`default_nettype wire

// File: rtl/main_memory.sv
// Word memory with fixed-latency pipelined reads; contents start undefined and bit 0 of addr is ignored
`timescale 1ns/10ps
`default_nettype none

module main_memory (
    input  logic           clk,
    input  logic           rst_n,
    input  mem_pkg::addr_t addr,
    input  mem_pkg::word_t write_data,
    input  logic           rd,
    input  logic           wr,
    output mem_pkg::word_t read_data,
    output logic           data_valid
);

    mem_pkg::word_t mem_array [mem_pkg::MEM_WORDS];
    mem_pkg::word_t data_pipe [mem_pkg::MEM_LATENCY];   // Read data in flight
    logic [mem_pkg::MEM_LATENCY-1:0] vld_pipe;          // One valid flag per stage

    // Array and data stages hold payload only
    always_ff @(posedge clk) begin
        if (wr) begin
            mem_array[addr[15:1]] <= write_data;        // Write lands at the sampling edge
        end
        if (rd) begin
            data_pipe[0] <= mem_array[addr[15:1]];      // Same-edge write is not seen here
        end
        for (int i = 1; i < mem_pkg::MEM_LATENCY; i++) begin
            data_pipe[i] <= data_pipe[i-1];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vld_pipe <= '0;
        end else begin
            vld_pipe <= {vld_pipe[mem_pkg::MEM_LATENCY-2:0], rd}; // New read at stage 0
        end
    end

    assign read_data  = data_pipe[mem_pkg::MEM_LATENCY-1];
    assign data_valid = vld_pipe[mem_pkg::MEM_LATENCY-1]; // Out MEM_LATENCY cycles after rd

endmodule

`default_nettype wire

// File: rtl/mem_subsystem_top.sv
// Memory subsystem top; the caches sit outside and must hold each miss level until their tag write
`timescale 1ns/10ps
`default_nettype none

module mem_subsystem_top (
    input  logic           clk,
    input  logic           rst_n,
    output logic           stall_n,

    input  mem_pkg::addr_t icache_addr,
    input  logic           icache_miss_detected,
    output logic           icache_fsm_busy,
    output logic           icache_write_data_array,
    output logic           icache_write_tag_array,
    output mem_pkg::addr_t icache_fill_addr,
    output mem_pkg::word_t icache_fill_data,

    input  mem_pkg::addr_t dcache_addr,
    input  logic           dcache_miss_detected,
    output logic           dcache_fsm_busy,
    output logic           dcache_write_data_array,
    output logic           dcache_write_tag_array,
    output mem_pkg::addr_t dcache_fill_addr,
    output mem_pkg::word_t dcache_fill_data,
    input  mem_pkg::addr_t dcache_write_addr,
    input  mem_pkg::word_t dcache_write_data,
    input  logic           dcache_write_enable
);

    mem_pkg::addr_t mem_addr;
    mem_pkg::word_t mem_write_data;
    mem_pkg::word_t mem_read_data;
    logic           mem_rd;
    logic           mem_wr;
    logic           mem_data_valid;

    cache_arbiter u_arbiter (
        .clk                     (clk),
        .rst_n                   (rst_n),
        .stall_n                 (stall_n),
        .icache_addr             (icache_addr),
        .icache_miss_detected    (icache_miss_detected),
        .icache_fsm_busy         (icache_fsm_busy),
        .icache_write_data_array (icache_write_data_array),
        .icache_write_tag_array  (icache_write_tag_array),
        .icache_fill_addr        (icache_fill_addr),
        .icache_fill_data        (icache_fill_data),
        .dcache_addr             (dcache_addr),
        .dcache_miss_detected    (dcache_miss_detected),
        .dcache_fsm_busy         (dcache_fsm_busy),
        .dcache_write_data_array (dcache_write_data_array),
        .dcache_write_tag_array  (dcache_write_tag_array),
        .dcache_fill_addr        (dcache_fill_addr),
        .dcache_fill_data        (dcache_fill_data),
        .dcache_write_addr       (dcache_write_addr),
        .dcache_write_data       (dcache_write_data),
        .dcache_write_enable     (dcache_write_enable),
        .mem_addr                (mem_addr),
        .mem_write_data          (mem_write_data),
        .mem_rd                  (mem_rd),
        .mem_wr                  (mem_wr),
        .mem_read_data           (mem_read_data),
        .mem_data_valid          (mem_data_valid)
    );

    main_memory u_memory (
        .clk        (clk),
        .rst_n      (rst_n),
        .addr       (mem_addr),
        .write_data (mem_write_data),
        .rd         (mem_rd),
        .wr         (mem_wr),
        .read_data  (mem_read_data),
        .data_valid (mem_data_valid)
    );

endmodule

`default_nettype wire

// File: dv/tb_mem_subsystem.sv
// Memory subsystem testbench; stores only run with no fill active and misses hit stored blocks
`timescale 1ns/10ps
`default_nettype none

module tb_mem_subsystem;

    localparam int FILL_CYCLES    = 13;                       // Busy length of one block fill
    localparam int DIRECTED_FILLS = 4;
    localparam int DIRECTED_BLKS  = 4;
    localparam int RANDOM_OPS     = 10;
    localparam int MAX_FILLS      = DIRECTED_FILLS + 2 * RANDOM_OPS;  // Overlaps count twice
    localparam int WRITE_CYCLES   = (DIRECTED_BLKS + RANDOM_OPS) * (cache_pkg::WORDS_PER_BLOCK + 1);
    localparam int TIMEOUT_CYCLES = MAX_FILLS * FILL_CYCLES + WRITE_CYCLES + 200;

    logic           clk = 1'b0;
    logic           rst_n;
    logic           stall_n;
    mem_pkg::addr_t icache_addr;
    logic           icache_miss_detected;
    logic           icache_fsm_busy;
    logic           icache_write_data_array;
    logic           icache_write_tag_array;
    mem_pkg::addr_t icache_fill_addr;
    mem_pkg::word_t icache_fill_data;
    mem_pkg::addr_t dcache_addr;
    logic           dcache_miss_detected;
    logic           dcache_fsm_busy;
    logic           dcache_write_data_array;
    logic           dcache_write_tag_array;
    mem_pkg::addr_t dcache_fill_addr;
    mem_pkg::word_t dcache_fill_data;
    mem_pkg::addr_t dcache_write_addr;
    mem_pkg::word_t dcache_write_data;
    logic           dcache_write_enable;

    mem_pkg::word_t ref_mem   [mem_pkg::MEM_WORDS];       // Mirror of every store
    mem_pkg::addr_t blocks [$];                           // Block bases that are fully stored
    logic [31:0]    rng_state;

    // Index 0 is the instruction cache, index 1 the data cache
    mem_pkg::addr_t exp_base    [2];                      // Set by the stimulus when a miss rises
    int             word_idx    [2];
    int             busy_len    [2];
    int             tag_cycle   [2];
    int             first_cycle [2];
    int             chk_cycle     = 0;
    int             fills_seen    = 0;
    int             fills_started = 0;

    mem_subsystem_top u_dut (
        .clk                     (clk),
        .rst_n                   (rst_n),
        .stall_n                 (stall_n),
        .icache_addr             (icache_addr),
        .icache_miss_detected    (icache_miss_detected),
        .icache_fsm_busy         (icache_fsm_busy),
        .icache_write_data_array (icache_write_data_array),
        .icache_write_tag_array  (icache_write_tag_array),
        .icache_fill_addr        (icache_fill_addr),
        .icache_fill_data        (icache_fill_data),
        .dcache_addr             (dcache_addr),
        .dcache_miss_detected    (dcache_miss_detected),
        .dcache_fsm_busy         (dcache_fsm_busy),
        .dcache_write_data_array (dcache_write_data_array),
        .dcache_write_tag_array  (dcache_write_tag_array),
        .dcache_fill_addr        (dcache_fill_addr),
        .dcache_fill_data        (dcache_fill_data),
        .dcache_write_addr       (dcache_write_addr),
        .dcache_write_data       (dcache_write_data),
        .dcache_write_enable     (dcache_write_enable)
    );

    initial begin
        forever begin
            #20 clk = ~clk;                               // 40 ns period
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Expected fill word is whatever the last store left at that address
    function automatic mem_pkg::word_t expected_word(input mem_pkg::addr_t a);
        return ref_mem[a[15:1]];
    endfunction

    task automatic report_failure(input string msg);
        $display("error at %0t ns: %s", $time, msg);
        $display("Checks failed");
        $fatal(1, "simulation stopped at the first failing check");
    endtask

    task automatic check_cache(input int c, input logic busy, input logic wda, input logic wta,
                               input mem_pkg::addr_t fa, input mem_pkg::word_t fd);
        mem_pkg::addr_t ea;
        ea = exp_base[c] + mem_pkg::addr_t'(2 * word_idx[c]);  // Words step by two bytes
        assert (!wta || wda) else report_failure($sformatf("cache %0d tag write alone", c));
        if (wda) begin
            assert (busy) else report_failure($sformatf("cache %0d array write while idle", c));
            assert (word_idx[c] < cache_pkg::WORDS_PER_BLOCK)
                else report_failure($sformatf("cache %0d got more than eight words", c));
            assert (fa == ea)
                else report_failure($sformatf("cache %0d fill_addr %h, expected %h", c, fa, ea));
            assert (fd == expected_word(ea))
                else report_failure($sformatf("cache %0d fill_data %h at %h, expected %h",
                                              c, fd, ea, expected_word(ea)));
            assert (wta == (word_idx[c] == cache_pkg::WORDS_PER_BLOCK - 1))
                else report_failure($sformatf("cache %0d tag write on word %0d", c, word_idx[c]));
            if (word_idx[c] == 0) begin
                first_cycle[c] = chk_cycle;               // Used by the ordering check
            end
            if (wta) begin
                tag_cycle[c] = chk_cycle;
            end
            word_idx[c] = word_idx[c] + 1;
        end
        if (busy) begin
            busy_len[c] = busy_len[c] + 1;
        end else if (busy_len[c] != 0) begin              // Busy just fell, so a fill ended
            assert (busy_len[c] == FILL_CYCLES)
                else report_failure($sformatf("cache %0d busy for %0d cycles", c, busy_len[c]));
            assert (word_idx[c] == cache_pkg::WORDS_PER_BLOCK)
                else report_failure($sformatf("cache %0d fill ended after %0d words",
                                              c, word_idx[c]));
            busy_len[c] = 0;
            word_idx[c] = 0;
            fills_seen  = fills_seen + 1;
        end
    endtask

    // Compare process samples in the middle of each cycle
    always @(negedge clk) begin
        chk_cycle = chk_cycle + 1;
        if (!rst_n) begin
            assert (stall_n && !icache_fsm_busy && !dcache_fsm_busy)
                else report_failure("stall or busy active during reset");
            assert (!icache_write_data_array && !icache_write_tag_array &&
                    !dcache_write_data_array && !dcache_write_tag_array)
                else report_failure("array write during reset");
        end else begin
            assert (stall_n == !(icache_fsm_busy || dcache_fsm_busy))
                else report_failure($sformatf("stall_n %b with busy %b/%b", stall_n,
                                              icache_fsm_busy, dcache_fsm_busy));
            assert (!(icache_fsm_busy && dcache_fsm_busy)) else report_failure("both fills busy");
            assert (stall_n || !dcache_write_enable) else report_failure("store during a stall");
            check_cache(0, icache_fsm_busy, icache_write_data_array, icache_write_tag_array,
                        icache_fill_addr, icache_fill_data);
            check_cache(1, dcache_fsm_busy, dcache_write_data_array, dcache_write_tag_array,
                        dcache_fill_addr, dcache_fill_data);
        end
    end

    task automatic new_block(output mem_pkg::addr_t b);
        rng_state = xorshift32(rng_state);
        b = rng_state[15:0] & 16'hfff0;                   // 16-byte aligned base
    endtask

    task automatic stored_block(output mem_pkg::addr_t a);
        int idx;
        rng_state = xorshift32(rng_state);
        idx = int'(rng_state % 32'(blocks.size()));
        a = blocks[idx] | mem_pkg::addr_t'(rng_state[19:16]);  // Any byte inside the block
    endtask

    task automatic store_block(input mem_pkg::addr_t base);
        mem_pkg::addr_t a;
        for (int w = 0; w < cache_pkg::WORDS_PER_BLOCK; w++) begin
            rng_state = xorshift32(rng_state);
            a = base + mem_pkg::addr_t'(2 * w);
            @(posedge clk);
            dcache_write_enable <= 1'b1;
            dcache_write_addr   <= a;
            dcache_write_data   <= rng_state[15:0];
            ref_mem[a[15:1]]    = rng_state[15:0];
        end
        @(posedge clk);
        dcache_write_enable <= 1'b0;                      // Last word is taken at this edge
        blocks.push_back(base);
    endtask

    task automatic wait_idle();
        do begin
            @(negedge clk);
        end while (icache_fsm_busy || dcache_fsm_busy);
    endtask

    // Cache models raise each miss after its delay and drop it on the edge after its tag write
    task automatic run_misses(input logic do_i, input mem_pkg::addr_t ia, input int i_delay,
                              input logic do_d, input mem_pkg::addr_t da, input int d_delay);
        logic i_tag;
        logic d_tag;
        logic i_done;
        logic d_done;
        int   cyc;
        i_tag  = 1'b0;
        d_tag  = 1'b0;
        i_done = !do_i;
        d_done = !do_d;
        cyc    = 0;
        while (!(i_done && d_done)) begin
            @(posedge clk);
            if (do_i && cyc == i_delay) begin
                exp_base[0] = ia & 16'hfff0;
                icache_addr          <= ia;
                icache_miss_detected <= 1'b1;
                fills_started = fills_started + 1;
            end
            if (do_d && cyc == d_delay) begin
                exp_base[1] = da & 16'hfff0;
                dcache_addr          <= da;
                dcache_miss_detected <= 1'b1;
                fills_started = fills_started + 1;
            end
            if (i_tag) begin
                icache_miss_detected <= 1'b0;
                i_tag  = 1'b0;
                i_done = 1'b1;
            end
            if (d_tag) begin
                dcache_miss_detected <= 1'b0;
                d_tag  = 1'b0;
                d_done = 1'b1;
            end
            cyc = cyc + 1;
            @(negedge clk);
            i_tag = icache_miss_detected && icache_write_tag_array;
            d_tag = dcache_miss_detected && dcache_write_tag_array;
        end
        wait_idle();
    endtask

    // The cache that misses first, the instruction cache on a tie, must finish before the other
    task automatic run_overlap(input mem_pkg::addr_t ia, input mem_pkg::addr_t da,
                               input int i_delay, input int d_delay);
        run_misses(1'b1, ia, i_delay, 1'b1, da, d_delay);
        if (d_delay < i_delay) begin
            assert (first_cycle[0] > tag_cycle[1])
                else report_failure("instruction fill wrote before the data tag write");
        end else begin
            assert (first_cycle[1] > tag_cycle[0])
                else report_failure("data fill wrote before the instruction tag write");
        end
    endtask

    initial begin
        mem_pkg::addr_t b;
        mem_pkg::addr_t a;
        mem_pkg::addr_t a2;
        int             dly;
        rng_state            = 32'hf9eb;
        rst_n                = 1'b0;
        icache_addr          = '0;
        icache_miss_detected = 1'b0;
        dcache_addr          = '0;
        dcache_miss_detected = 1'b0;
        dcache_write_addr    = '0;
        dcache_write_data    = '0;
        dcache_write_enable  = 1'b0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        assert (stall_n && !icache_fsm_busy && !dcache_fsm_busy)
            else report_failure("not idle right after reset");
        new_block(b);                                     // Instruction fill of a stored block
        store_block(b);
        stored_block(a);
        run_misses(1'b1, b | (a & 16'h000f), 0, 1'b0, '0, 0);
        new_block(b);                                     // Data fill
        store_block(b);
        run_misses(1'b0, '0, 0, 1'b1, b | 16'h0007, 0);
        new_block(b);                                     // Both misses in the same cycle
        store_block(b);
        a = b | 16'h000c;
        new_block(b);
        store_block(b);
        run_overlap(a, b, 0, 0);
        for (int op = 0; op < RANDOM_OPS; op++) begin
            rng_state = xorshift32(rng_state);
            case (rng_state[1:0])
                2'd0: begin
                    new_block(b);
                    store_block(b);
                end
                2'd1: begin
                    stored_block(a);
                    run_misses(1'b1, a, 0, 1'b0, '0, 0);
                end
                2'd2: begin
                    stored_block(a);
                    run_misses(1'b0, '0, 0, 1'b1, a, 0);
                end
                default: begin
                    dly = int'(rng_state[5:4]);           // Zero gives a simultaneous miss
                    stored_block(a);
                    stored_block(a2);
                    if (rng_state[6]) begin
                        run_overlap(a, a2, dly, 0);
                    end else begin
                        run_overlap(a, a2, 0, dly);
                    end
                end
            endcase
        end
        @(negedge clk);                                   // Let the compare process see the last fall
        assert (fills_seen == fills_started) begin
            $display("All checks passed");
            $finish;
        end else begin
            report_failure($sformatf("%0d fills ended, %0d started", fills_seen,
                                     fills_started));
        end
    end

    initial begin
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles = cycles + 1;
        end
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Checks failed");
        $fatal(1, "simulation stopped by the cycle limit");
    end

endmodule

`default_nettype wire

// File: src.f
rtl/mem_pkg.sv
rtl/cache_pkg.sv
rtl/cache_fill_fsm.sv
rtl/cache_arbiter.sv
rtl/main_memory.sv
rtl/mem_subsystem_top.sv
dv/tb_mem_subsystem.sv

// File: run.sh
#!/bin/sh
# Build and run with Verilator, then judge the run from sim.log
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert --timescale 1ns/10ps -f src.f \
    --top-module tb_mem_subsystem -o tb_sim > build.log 2>&1 \
    || { echo "FAIL: build error, see build.log"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
grep -q "Checks failed" sim.log && { echo "FAIL: see sim.log"; exit 1; }
grep -q "All checks passed" sim.log || { echo "FAIL: no result in sim.log"; exit 1; }
echo "PASS"
